/* hw/archPkg.sv */
package archPkg;

  // width of a general register and of the data bus
  localparam int wordW = 32;

  // number of byte lanes on the data bus
  localparam int laneCount = wordW / 8;

  typedef logic [wordW-1:0] word;

  // r0 to r31
  typedef logic [4:0] regIdx;

  // one bit per byte, bit 3 is the highest byte
  typedef logic [laneCount-1:0] laneMask;

  // word address of an instruction, the low two bits are implied zero
  typedef logic [wordW-3:0] pcWord;

  // memory access size, taken from the low opcode bits
  typedef enum logic [1:0] {
    sizeByte = 2'b00,
    sizeHalf = 2'b01,
    sizeWord = 2'b10
  } accessSize;

  // source of the value written back to the register bank
  typedef enum logic [1:0] {
    wbAlu  = 2'b00,
    wbLink = 2'b01,
    wbLoad = 2'b10
  } wbSrc;

endpackage

/* hw/loadSizer.sv */
`timescale 1ns/100ps

module loadSizer (
  input  logic            gclk,
  input  logic            arstN,
  input  pipePkg::loadRsp loadIn,
  output archPkg::word    loadWord
);

  archPkg::word alignedWord;

  // pick the addressed bytes and move them to the low end
  always_comb begin
    case (loadIn.lanes)
      // bytes
      4'h8: alignedWord = {24'd0, loadIn.data[31:24]};
      4'h4: alignedWord = {24'd0, loadIn.data[23:16]};
      4'h2: alignedWord = {24'd0, loadIn.data[15:8]};
      4'h1: alignedWord = {24'd0, loadIn.data[7:0]};
      // halfwords
      4'hC: alignedWord = {16'd0, loadIn.data[31:16]};
      4'h3: alignedWord = {16'd0, loadIn.data[15:0]};
      // full word
      4'hF: alignedWord = loadIn.data;
      default: alignedWord = '0;
    endcase
  end

  // held until the next cache response
  always_ff @(posedge gclk or negedge arstN) begin
    if (!arstN) begin
      loadWord <= '0;
    end else if (loadIn.valid) begin
      loadWord <= alignedWord;
    end
  end

  // the cache only returns aligned, naturally sized lanes
  assert property (@(posedge gclk) disable iff (!arstN)
    loadIn.valid |-> loadIn.lanes inside {4'h8, 4'h4, 4'h2, 4'h1, 4'hC, 4'h3, 4'hF})
    else $error("loadSizer unaligned lane mask %h", loadIn.lanes);

endmodule

/* hw/operandPath.sv */
`timescale 1ns/100ps

module operandPath #(
  parameter int numRegs = 32
) (
  input  logic            gclk,
  input  logic            arstN,
  input  pipePkg::readReq readIn,
  input  pipePkg::loadRsp loadIn,
  input  pipePkg::wbReq   wbIn,
  output pipePkg::readRsp readOut
);

  archPkg::word       loadWord;
  pipePkg::regWrite   regWr;
  archPkg::word       opA;
  archPkg::word       opB;
  archPkg::word       rdValue;
  archPkg::accessSize storeSizeQ;
  archPkg::word       storeData;
  logic               rspValid;

  // aligned load data for writeback
  loadSizer uLoadSizer (
    .gclk     (gclk),
    .arstN    (arstN),
    .loadIn   (loadIn),
    .loadWord (loadWord)
  );

  writebackMux uWritebackMux (
    .wbIn     (wbIn),
    .loadWord (loadWord),
    .writeOut (regWr)
  );

  regBank #(
    .numRegs (numRegs)
  ) uRegBank (
    .gclk       (gclk),
    .arstN      (arstN),
    .readIn     (readIn),
    .writeIn    (regWr),
    .opA        (opA),
    .opB        (opB),
    .rdValue    (rdValue),
    .storeSizeQ (storeSizeQ),
    .rspValid   (rspValid)
  );

  // store lanes follow the size registered with the read
  storeSizer uStoreSizer (
    .rdValue    (rdValue),
    .storeSizeQ (storeSizeQ),
    .storeData  (storeData)
  );

  always_comb begin
    readOut.valid     = rspValid;
    readOut.opA       = opA;
    readOut.opB       = opB;
    readOut.storeData = storeData;
  end

endmodule

/* hw/pipePkg.sv */
package pipePkg;

  // operand fetch request from the decoder
  typedef struct packed {
    logic               valid;
    archPkg::regIdx     ra;
    archPkg::regIdx     rb;
    archPkg::regIdx     rd;
    archPkg::accessSize storeSize;
  } readReq;

  // operands and store data for execute and the cache write port
  typedef struct packed {
    logic         valid;
    archPkg::word opA;
    archPkg::word opB;
    archPkg::word storeData;
  } readRsp;

  // read data returned by the data cache
  typedef struct packed {
    logic             valid;
    archPkg::word     data;
    archPkg::laneMask lanes;
  } loadRsp;

  // writeback request, one destination and one source select
  typedef struct packed {
    logic           valid;
    archPkg::regIdx dest;
    archPkg::wbSrc  src;
    archPkg::word   aluResult;
    archPkg::pcWord pcWord;
  } wbReq;

  // single write port into the register bank
  typedef struct packed {
    logic           en;
    archPkg::regIdx addr;
    archPkg::word   data;
  } regWrite;

endpackage

/* hw/regBank.sv */
`timescale 1ns/100ps

module regBank #(
  parameter int numRegs = 32
) (
  input  logic               gclk,
  input  logic               arstN,
  input  pipePkg::readReq    readIn,
  input  pipePkg::regWrite   writeIn,
  output archPkg::word       opA,
  output archPkg::word       opB,
  output archPkg::word       rdValue,
  output archPkg::accessSize storeSizeQ,
  output logic               rspValid
);

  localparam int idxW = $clog2(numRegs);

  archPkg::word regs [numRegs];

  // one read port with write-first bypass
  function automatic archPkg::word readPort(archPkg::regIdx idx);
    archPkg::word value;
    if (idx == '0 || int'(idx) >= numRegs) begin
      // r0 is hardwired
      value = '0;
    end else if (writeIn.en && writeIn.addr == idx) begin
      value = writeIn.data;
    end else begin
      value = regs[idx[idxW-1:0]];
    end
    return value;
  endfunction

  // r0 is never stored
  always_ff @(posedge gclk) begin
    if (writeIn.en && writeIn.addr != '0 && int'(writeIn.addr) < numRegs) begin
      regs[writeIn.addr[idxW-1:0]] <= writeIn.data;
    end
  end

  // three reads on one decode strobe
  always_ff @(posedge gclk) begin
    if (readIn.valid) begin
      opA        <= readPort(readIn.ra);
      opB        <= readPort(readIn.rb);
      rdValue    <= readPort(readIn.rd);
      storeSizeQ <= readIn.storeSize;
    end
  end

  always_ff @(posedge gclk or negedge arstN) begin
    if (!arstN) begin
      rspValid <= 1'b0;
    end else begin
      rspValid <= readIn.valid;
    end
  end

  // writeback stage must stay inside the bank
  assert property (@(posedge gclk) disable iff (!arstN)
    writeIn.en |-> int'(writeIn.addr) < numRegs)
    else $error("regBank write to index %0d beyond %0d registers", writeIn.addr, numRegs);

endmodule

/* hw/storeSizer.sv */
`timescale 1ns/100ps

module storeSizer (
  input  archPkg::word       rdValue,
  input  archPkg::accessSize storeSizeQ,
  output archPkg::word       storeData
);

  // low bytes of rd, used for the narrow sizes
  logic [7:0]  lowByte;
  logic [15:0] lowHalf;

  assign lowByte = rdValue[7:0];
  assign lowHalf = rdValue[15:0];

  // the cache picks the lane from the address, so every lane carries the data
  always_comb begin
    case (storeSizeQ)
      archPkg::sizeByte: storeData = {4{lowByte}};
      archPkg::sizeHalf: storeData = {2{lowHalf}};
      archPkg::sizeWord: storeData = rdValue;
      default:           storeData = '0;
    endcase
  end

endmodule

/* hw/writebackMux.sv */
`timescale 1ns/100ps

module writebackMux (
  input  pipePkg::wbReq    wbIn,
  input  archPkg::word     loadWord,
  output pipePkg::regWrite writeOut
);

  archPkg::word linkAddr;
  archPkg::word wrData;
  logic         srcKnown;

  // return address for branch and link
  assign linkAddr = {wbIn.pcWord, 2'b00};

  always_comb begin
    srcKnown = 1'b1;
    case (wbIn.src)
      archPkg::wbAlu:  wrData = wbIn.aluResult;
      archPkg::wbLink: wrData = linkAddr;
      archPkg::wbLoad: wrData = loadWord;
      default: begin
        wrData   = '0;
        srcKnown = 1'b0;
      end
    endcase
  end

  // r0 is hardwired, so its writes never reach the bank
  always_comb begin
    writeOut.en   = wbIn.valid && srcKnown && (wbIn.dest != '0);
    writeOut.addr = wbIn.dest;
    writeOut.data = wrData;
  end

  // the writeback stage never issues the reserved source
  always_comb begin
    if (wbIn.valid) begin
      assert (wbIn.src inside {archPkg::wbAlu, archPkg::wbLink, archPkg::wbLoad})
        else $error("writebackMux reserved source %b for r%0d", wbIn.src, wbIn.dest);
    end
  end

endmodule

/* run.sh */
#!/bin/sh
# builds and runs the operandPath testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module operandPathTb -Mdir obj_dir -o operandPathSim \
  -f src.f > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat build.log
  echo "build failed with status $status"
  exit 1
fi

./obj_dir/operandPathSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Errors found" sim.log; then
  echo "FAIL"
  exit 1
fi

echo "PASS"
exit 0

/* sim/operandPathTb.sv */
`timescale 1ns/100ps

module operandPathTb;

  localparam int numRegs = 32;
  localparam int rspTimeout = 10;
  localparam int randomCycles = 200;

  logic            gclk;
  logic            arstN;
  pipePkg::readReq readIn;
  pipePkg::loadRsp loadIn;
  pipePkg::wbReq   wbIn;
  pipePkg::readRsp rsp;

  integer seed;
  int     checkErrors;
  int     timeouts;

  // shadow of the register bank and the held load word
  archPkg::word     shadow [numRegs];
  archPkg::word     shadowLoad;
  logic             wEn;
  archPkg::word     wData;
  logic             expValid;
  archPkg::word     expA;
  archPkg::word     expB;
  archPkg::word     expStore;
  logic             seenRead;
  archPkg::laneMask laneMasks [7] = '{4'h8, 4'h4, 4'h2, 4'h1, 4'hC, 4'h3, 4'hF};

  operandPath #(
    .numRegs (numRegs)
  ) DUT (
    .gclk    (gclk),
    .arstN   (arstN),
    .readIn  (readIn),
    .loadIn  (loadIn),
    .wbIn    (wbIn),
    .readOut (rsp)
  );

  initial begin
    gclk = 1'b0;
    forever #50 gclk = ~gclk;
  end

  // lowest selected lane moves to bit 0 and the upper bytes clear
  function automatic archPkg::word alignLoad(archPkg::word data, archPkg::laneMask lanes);
    archPkg::word value;
    int low;
    int count;
    low = 4;
    count = 0;
    for (int i = 0; i < 4; i++) begin
      if (lanes[i]) begin
        count++;
        if (low == 4) low = i;
      end
    end
    value = data >> (8 * low);
    if (count < 4) value = value & ((32'd1 << (8 * count)) - 1);
    return value;
  endfunction

  // each bus lane carries the byte that the access size maps to it
  function automatic archPkg::word replicateStore(archPkg::word data, archPkg::accessSize size);
    archPkg::word value;
    for (int i = 0; i < 4; i++) begin
      case (size)
        archPkg::sizeByte: value[8*i +: 8] = data[7:0];
        archPkg::sizeHalf: value[8*i +: 8] = data[8*(i%2) +: 8];
        default:           value[8*i +: 8] = data[8*i +: 8];
      endcase
    end
    return value;
  endfunction

  // r0 reads zero and a same-cycle write wins
  function automatic archPkg::word expectRead(archPkg::regIdx idx);
    if (idx == '0) return '0;
    if (wEn && wbIn.dest == idx) return wData;
    return shadow[idx];
  endfunction

  function automatic int randBelow(int n);
    int r;
    r = $random(seed);
    return (r & 32'h7fff_ffff) % n;
  endfunction

  always_comb begin
    wEn = wbIn.valid && (wbIn.dest != '0);
    case (wbIn.src)
      archPkg::wbLink: wData = archPkg::word'(wbIn.pcWord) << 2;
      archPkg::wbLoad: wData = shadowLoad;
      default:         wData = wbIn.aluResult;
    endcase
  end

  always @(posedge gclk or negedge arstN) begin
    if (!arstN) begin
      expValid   <= 1'b0;
      seenRead   <= 1'b0;
      shadowLoad <= '0;
    end else begin
      if (readIn.valid) begin
        expA     <= expectRead(readIn.ra);
        expB     <= expectRead(readIn.rb);
        expStore <= replicateStore(expectRead(readIn.rd), readIn.storeSize);
        seenRead <= 1'b1;
      end
      expValid <= readIn.valid;
      if (wEn) shadow[wbIn.dest] <= wData;
      if (loadIn.valid) shadowLoad <= alignLoad(loadIn.data, loadIn.lanes);
    end
  end

  // compared mid-cycle on the falling edge
  assert property (@(negedge gclk) disable iff (!arstN) rsp.valid == expValid)
    else begin
      checkErrors++;
      $display("ERROR readOut.valid got %h expected %h", rsp.valid, expValid);
    end

  assert property (@(negedge gclk) disable iff (!arstN) !seenRead |-> !rsp.valid)
    else begin
      checkErrors++;
      $display("readOut.valid went high before any read request");
    end

  assert property (@(negedge gclk) disable iff (!arstN) rsp.valid |-> rsp.opA == expA)
    else begin
      checkErrors++;
      $display("ERROR readOut.opA got %h expected %h", rsp.opA, expA);
    end

  assert property (@(negedge gclk) disable iff (!arstN) rsp.valid |-> rsp.opB == expB)
    else begin
      checkErrors++;
      $display("ERROR readOut.opB got %h expected %h", rsp.opB, expB);
    end

  assert property (@(negedge gclk) disable iff (!arstN) rsp.valid |-> rsp.storeData == expStore)
    else begin
      checkErrors++;
      $display("ERROR readOut.storeData got %h expected %h", rsp.storeData, expStore);
    end

  function automatic pipePkg::readReq readRequest(archPkg::regIdx ra, archPkg::regIdx rb,
                                                  archPkg::regIdx rd, archPkg::accessSize size);
    return '{valid: 1'b1, ra: ra, rb: rb, rd: rd, storeSize: size};
  endfunction

  function automatic pipePkg::wbReq writeRequest(archPkg::regIdx dest, archPkg::wbSrc src,
                                                 archPkg::word value, archPkg::pcWord pc);
    return '{valid: 1'b1, dest: dest, src: src, aluResult: value, pcWord: pc};
  endfunction

  function automatic pipePkg::loadRsp loadResponse(archPkg::word data, archPkg::laneMask lanes);
    return '{valid: 1'b1, data: data, lanes: lanes};
  endfunction

  // one clock of stimulus on all three inputs
  task automatic driveCycle(pipePkg::readReq r, pipePkg::wbReq w, pipePkg::loadRsp l);
    @(posedge gclk);
    readIn <= r;
    wbIn   <= w;
    loadIn <= l;
  endtask

  task automatic driveIdle();
    driveCycle('0, '0, '0);
  endtask

  task automatic awaitReadRsp();
    int cycles;
    cycles = 0;
    do begin
      @(negedge gclk);
      cycles++;
    end while (!rsp.valid && cycles < rspTimeout);
    if (!rsp.valid) begin
      timeouts++;
      $display("read response did not arrive within %0d cycles", rspTimeout);
    end
  endtask

  task automatic writeBack(archPkg::regIdx dest, archPkg::wbSrc src, archPkg::word value,
                           archPkg::pcWord pc);
    driveCycle('0, writeRequest(dest, src, value, pc), '0);
  endtask

  task automatic readBack(archPkg::regIdx ra, archPkg::regIdx rb, archPkg::regIdx rd,
                          archPkg::accessSize size);
    driveCycle(readRequest(ra, rb, rd, size), '0, '0);
    driveIdle();
    awaitReadRsp();
  endtask

  function automatic archPkg::regIdx nonZeroIdx();
    archPkg::regIdx idx;
    idx = archPkg::regIdx'(randBelow(numRegs - 1) + 1);
    return idx;
  endfunction

  initial begin
    archPkg::regIdx idx;
    archPkg::word   value;
    seed = 32'hb6aa_83c1;
    checkErrors = 0;
    timeouts = 0;
    arstN = 1'b0;
    readIn = '0;
    loadIn = '0;
    wbIn = '0;
    repeat (4) @(posedge gclk);
    arstN <= 1'b1;
    // quiet after reset so valid stays low
    repeat (3) driveIdle();
    // give every register a known value
    for (int i = 1; i < numRegs; i++) begin
      writeBack(archPkg::regIdx'(i), archPkg::wbAlu, $random(seed), '0);
    end
    for (int i = 0; i < 8; i++) begin
      idx = nonZeroIdx();
      writeBack(idx, archPkg::wbAlu, $random(seed), '0);
      readBack(idx, nonZeroIdx(), '0, archPkg::sizeWord);
    end
    // r0 stays zero before and during a write to it
    writeBack('0, archPkg::wbAlu, $random(seed), '0);
    readBack('0, '0, '0, archPkg::sizeWord);
    driveCycle(readRequest('0, '0, '0, archPkg::sizeWord),
               writeRequest('0, archPkg::wbAlu, $random(seed), '0), '0);
    driveIdle();
    awaitReadRsp();
    // same-cycle bypass
    for (int i = 0; i < 6; i++) begin
      idx = nonZeroIdx();
      driveCycle(readRequest(idx, idx, idx, archPkg::sizeWord),
                 writeRequest(idx, archPkg::wbAlu, $random(seed), '0), '0);
      driveIdle();
      awaitReadRsp();
    end
    // load lanes through wbLoad
    for (int m = 0; m < 7; m++) begin
      idx = nonZeroIdx();
      value = $random(seed);
      driveCycle('0, '0, loadResponse(value, laneMasks[m]));
      writeBack(idx, archPkg::wbLoad, $random(seed), '0);
      readBack(idx, '0, idx, archPkg::sizeWord);
    end
    // link address from the PC word
    for (int i = 0; i < 4; i++) begin
      idx = nonZeroIdx();
      writeBack(idx, archPkg::wbLink, $random(seed), archPkg::pcWord'($random(seed)));
      readBack(idx, idx, '0, archPkg::sizeWord);
    end
    // store replication for each size
    for (int s = 0; s < 3; s++) begin
      idx = nonZeroIdx();
      writeBack(idx, archPkg::wbAlu, $random(seed), '0);
      readBack(nonZeroIdx(), nonZeroIdx(), idx, archPkg::accessSize'(s));
    end
    // mixed traffic on all ports
    for (int c = 0; c < randomCycles; c++) begin
      driveCycle(
        randBelow(2) == 1 ? readRequest(archPkg::regIdx'(randBelow(numRegs)),
                                        archPkg::regIdx'(randBelow(numRegs)),
                                        archPkg::regIdx'(randBelow(numRegs)),
                                        archPkg::accessSize'(randBelow(3))) : '0,
        randBelow(2) == 1 ? writeRequest(archPkg::regIdx'(randBelow(numRegs)),
                                         archPkg::wbSrc'(randBelow(3)), $random(seed),
                                         archPkg::pcWord'($random(seed))) : '0,
        randBelow(3) == 0 ? loadResponse($random(seed), laneMasks[randBelow(7)]) : '0);
    end
    repeat (3) driveIdle();
    $display("checks failed: %0d, timeouts: %0d", checkErrors, timeouts);
    if (checkErrors == 0 && timeouts == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* src.f */
hw/archPkg.sv
hw/pipePkg.sv
hw/regBank.sv
hw/loadSizer.sv
hw/writebackMux.sv
hw/storeSizer.sv
hw/operandPath.sv
sim/operandPathTb.sv
